// ==== design/flash_pkg.sv ====
package flash_pkg;

  localparam int flash_addr_w = 25;
  localparam int flash_data_w = 16;

  localparam logic [15:0] cmd_unlock_set = 16'h0060;
  localparam logic [15:0] cmd_confirm    = 16'h00d0;
  localparam logic [15:0] cmd_erase_set  = 16'h0020;
  localparam logic [15:0] cmd_program    = 16'h0040;
  localparam logic [15:0] cmd_read_array = 16'h00ff;

  localparam logic [4:0] erase_poll_delay  = 5'd20;  // Idle cycles before the first status read
  localparam logic [2:0] we_pulse_cycles   = 3'd3;
  localparam logic [2:0] rd_latency_cycles = 3'd4;

  localparam logic [7:0] reg_addr   = 8'h00;
  localparam logic [7:0] reg_wdata  = 8'h04;
  localparam logic [7:0] reg_cmd    = 8'h08;
  localparam logic [7:0] reg_status = 8'h0c;
  localparam logic [7:0] reg_rdata  = 8'h10;

  localparam logic [1:0] axi_okay   = 2'b00;
  localparam logic [1:0] axi_slverr = 2'b10;

  localparam logic [7:0] status_ready = 8'h80;  // Ready with no error bits

  typedef enum logic [1:0] {op_none, op_erase, op_program, op_read} flash_op_e;

  typedef struct packed {
    flash_op_e               op;
    logic [flash_addr_w-1:0] addr;
    logic [flash_data_w-1:0] wdata;
  } flash_cmd_t;

  typedef struct packed {
    logic                    valid;
    logic                    write;  // Low for a read cycle
    logic [flash_addr_w-1:0] addr;
    logic [flash_data_w-1:0] data;
  } flash_req_t;

  typedef struct packed {
    logic                    done;
    logic [flash_data_w-1:0] rdata;
  } flash_rsp_t;

  typedef struct packed {
    logic [7:0] rsvd_hi;
    logic       ready;
    logic       erase_susp;
    logic       erase_err;
    logic       prog_err;
    logic       vpp_err;
    logic       prog_susp;
    logic       lock_err;
    logic       rsvd;
  } flash_status_t;

  // The same bus word is array data or the status register
  typedef union packed {
    logic [flash_data_w-1:0] raw;
    flash_status_t           status;
  } flash_word_u;

  typedef struct packed {
    logic                    done;
    logic [7:0]              status;
    logic [flash_data_w-1:0] rdata;
  } flash_result_t;

endpackage

// ==== design/flash_axil_regs.sv ====
module flash_axil_regs (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic [7:0]               s_awaddr,
  input  logic                     s_awvalid,
  output logic                     s_awready,
  input  logic [31:0]              s_wdata,
  input  logic [3:0]               s_wstrb,
  input  logic                     s_wvalid,
  output logic                     s_wready,
  output logic [1:0]               s_bresp,
  output logic                     s_bvalid,
  input  logic                     s_bready,
  input  logic [7:0]               s_araddr,
  input  logic                     s_arvalid,
  output logic                     s_arready,
  output logic [31:0]              s_rdata,
  output logic [1:0]               s_rresp,
  output logic                     s_rvalid,
  input  logic                     s_rready,
  output flash_pkg::flash_cmd_t    cmd,
  output logic                     start,
  input  flash_pkg::flash_result_t erase_res,
  input  flash_pkg::flash_result_t word_res
);

  logic                                 aw_full;
  logic                                 w_full;
  logic [7:0]                           aw_q;
  logic [31:0]                          wd_q;
  logic [3:0]                           ws_q;
  logic [31:0]                          wmerge;
  logic [2:0]                           op_bits;
  logic                                 do_write;
  logic [flash_pkg::flash_addr_w-1:0]   addr_q;
  logic [flash_pkg::flash_data_w-1:0]   wdata_q;
  logic [flash_pkg::flash_data_w-1:0]   rdata_q;
  flash_pkg::flash_op_e                 op_q;
  logic                                 busy_q;
  logic                                 done_q;
  logic [7:0]                           stat_q;
  flash_pkg::flash_result_t             fin;

  assign s_awready = !aw_full && !s_bvalid;
  assign s_wready  = !w_full && !s_bvalid;
  assign s_arready = !s_rvalid;
  assign do_write  = aw_full && w_full && !s_bvalid;  // Both halves taken, in either order
  assign op_bits   = wd_q[2:0] & {3{ws_q[0]}};
  assign fin       = erase_res.done ? erase_res : word_res;  // The idle sequencer keeps old data
  assign cmd       = '{op: op_q, addr: addr_q, wdata: wdata_q};

  always_comb
  begin
    wmerge = (aw_q == flash_pkg::reg_addr) ? {7'd0, addr_q} : {16'd0, wdata_q};
    for (int i = 0; i < 4; i++)
    begin
      if (ws_q[i])
        wmerge[8*i +: 8] = wd_q[8*i +: 8];
    end
  end

  always_ff @(posedge clk)
  begin
    if (s_awvalid && s_awready)
      aw_q <= s_awaddr;
    if (s_wvalid && s_wready)
    begin
      wd_q <= s_wdata;
      ws_q <= s_wstrb;
    end
    if (do_write && aw_q == flash_pkg::reg_addr)
      addr_q <= wmerge[flash_pkg::flash_addr_w-1:0];
    if (do_write && aw_q == flash_pkg::reg_wdata)
      wdata_q <= wmerge[flash_pkg::flash_data_w-1:0];
    if (fin.done)
      rdata_q <= fin.rdata;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      aw_full  <= 1'b0;
      w_full   <= 1'b0;
      s_bvalid <= 1'b0;
      s_bresp  <= flash_pkg::axi_okay;
      start    <= 1'b0;
      op_q     <= flash_pkg::op_none;
      busy_q   <= 1'b0;
      done_q   <= 1'b0;
      stat_q   <= 8'd0;
    end
    else
    begin
      start <= 1'b0;
      if (s_awvalid && s_awready)
        aw_full <= 1'b1;
      if (s_wvalid && s_wready)
        w_full <= 1'b1;
      if (s_bvalid && s_bready)
        s_bvalid <= 1'b0;
      if (fin.done)
      begin
        busy_q <= 1'b0;
        done_q <= 1'b1;
        stat_q <= fin.status;
      end
      if (do_write)
      begin
        aw_full  <= 1'b0;
        w_full   <= 1'b0;
        s_bvalid <= 1'b1;
        s_bresp  <= flash_pkg::axi_okay;
        if (aw_q == flash_pkg::reg_cmd)
        begin
          if (busy_q || !$onehot(op_bits))
            s_bresp <= flash_pkg::axi_slverr;  // Command dropped
          else
          begin
            start  <= 1'b1;
            busy_q <= 1'b1;
            done_q <= 1'b0;
            op_q   <= op_bits[0] ? flash_pkg::op_erase :
                      op_bits[1] ? flash_pkg::op_program : flash_pkg::op_read;
          end
        end
        else if (!(aw_q inside {flash_pkg::reg_addr, flash_pkg::reg_wdata,
                                flash_pkg::reg_status, flash_pkg::reg_rdata}))
          s_bresp <= flash_pkg::axi_slverr;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      s_rvalid <= 1'b0;
      s_rresp  <= flash_pkg::axi_okay;
      s_rdata  <= 32'd0;
    end
    else
    begin
      if (s_rvalid && s_rready)
        s_rvalid <= 1'b0;
      if (s_arvalid && s_arready)
      begin
        s_rvalid <= 1'b1;
        s_rresp  <= flash_pkg::axi_okay;
        case (s_araddr)
          flash_pkg::reg_addr:   s_rdata <= {7'd0, addr_q};
          flash_pkg::reg_wdata:  s_rdata <= {16'd0, wdata_q};
          flash_pkg::reg_cmd:    s_rdata <= 32'd0;  // Command bits are self-clearing
          flash_pkg::reg_status: s_rdata <= {16'd0, stat_q, 6'd0, done_q, busy_q};
          flash_pkg::reg_rdata:  s_rdata <= {16'd0, rdata_q};
          default:
          begin
            s_rdata <= 32'd0;
            s_rresp <= flash_pkg::axi_slverr;
          end
        endcase
      end
    end
  end

endmodule

// ==== design/flash_erase_seq.sv ====
module flash_erase_seq (
  input  logic                     clk,
  input  logic                     rst_n,
  input  flash_pkg::flash_cmd_t    cmd,
  input  logic                     start,
  output flash_pkg::flash_req_t    req,
  input  flash_pkg::flash_rsp_t    rsp,
  output flash_pkg::flash_result_t res
);

  typedef enum logic [7:0] {
    st_idle        = 8'b0000_0001,
    st_unlock_set  = 8'b0000_0010,
    st_unlock_conf = 8'b0000_0100,
    st_erase_set   = 8'b0000_1000,
    st_erase_conf  = 8'b0001_0000,
    st_wait        = 8'b0010_0000,
    st_poll        = 8'b0100_0000,
    st_read_array  = 8'b1000_0000
  } state_e;

  state_e                               state;
  logic [flash_pkg::flash_addr_w-1:0]   blk_addr;
  logic [4:0]                           wait_cnt;
  logic [7:0]                           stat_q;
  logic                                 res_done;
  logic [flash_pkg::flash_data_w-1:0]   wr_code;
  flash_pkg::flash_word_u               word;

  assign word.raw = rsp.rdata;
  assign res      = '{done: res_done, status: stat_q, rdata: '0};

  always_comb
  begin
    case (state)
      st_unlock_set:                 wr_code = flash_pkg::cmd_unlock_set;
      st_unlock_conf, st_erase_conf: wr_code = flash_pkg::cmd_confirm;
      st_erase_set:                  wr_code = flash_pkg::cmd_erase_set;
      default:                       wr_code = flash_pkg::cmd_read_array;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (start && cmd.op == flash_pkg::op_erase && state == st_idle)
      blk_addr <= cmd.addr;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= st_idle;
      req      <= '0;
      wait_cnt <= 5'd0;
      stat_q   <= 8'd0;
      res_done <= 1'b0;
    end
    else
    begin
      res_done <= 1'b0;
      case (state)
        st_idle:
        begin
          if (start && cmd.op == flash_pkg::op_erase)
            state <= st_unlock_set;
        end
        st_wait:
        begin
          wait_cnt <= wait_cnt + 5'd1;
          if (wait_cnt == flash_pkg::erase_poll_delay - 5'd1)
            state <= st_poll;
        end
        default:
        begin
          if (rsp.done)
          begin
            req.valid <= 1'b0;  // Gap of one cycle before the next request
            case (state)
              st_unlock_set:  state <= st_unlock_conf;
              st_unlock_conf: state <= st_erase_set;
              st_erase_set:   state <= st_erase_conf;
              st_erase_conf:
              begin
                wait_cnt <= 5'd0;
                state    <= st_wait;
              end
              st_poll:
              begin
                if (word.status.ready)
                begin
                  stat_q <= word.raw[7:0];  // Error bits go up unchanged
                  state  <= st_read_array;
                end
              end
              default:
              begin
                res_done <= 1'b1;
                state    <= st_idle;
              end
            endcase
          end
          else if (!req.valid)
            req <= '{valid: 1'b1, write: state != st_poll, addr: blk_addr, data: wr_code};
        end
      endcase
    end
  end

endmodule

// ==== design/flash_word_seq.sv ====
module flash_word_seq (
  input  logic                     clk,
  input  logic                     rst_n,
  input  flash_pkg::flash_cmd_t    cmd,
  input  logic                     start,
  output flash_pkg::flash_req_t    req,
  input  flash_pkg::flash_rsp_t    rsp,
  output flash_pkg::flash_result_t res
);

  typedef enum logic [5:0] {
    st_idle       = 6'b00_0001,
    st_prog_set   = 6'b00_0010,
    st_prog_data  = 6'b00_0100,
    st_poll       = 6'b00_1000,
    st_read_array = 6'b01_0000,
    st_read_word  = 6'b10_0000
  } state_e;

  state_e                               state;
  logic [flash_pkg::flash_addr_w-1:0]   addr_q;
  logic [flash_pkg::flash_data_w-1:0]   data_q;
  logic [flash_pkg::flash_data_w-1:0]   rdata_q;
  logic [flash_pkg::flash_data_w-1:0]   wr_word;
  logic [7:0]                           stat_q;
  logic                                 res_done;
  logic                                 is_read;
  flash_pkg::flash_word_u               word;

  assign word.raw = rsp.rdata;
  assign is_read  = state == st_poll || state == st_read_word;
  assign wr_word  = (state == st_prog_set)  ? flash_pkg::cmd_program :
                    (state == st_prog_data) ? data_q : flash_pkg::cmd_read_array;
  assign res      = '{done: res_done, status: stat_q, rdata: rdata_q};

  always_ff @(posedge clk)
  begin
    if (start && state == st_idle)
    begin
      addr_q <= cmd.addr;
      data_q <= cmd.wdata;
    end
    if (state == st_read_word && rsp.done)
      rdata_q <= rsp.rdata;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= st_idle;
      req      <= '0;
      stat_q   <= 8'd0;
      res_done <= 1'b0;
    end
    else
    begin
      res_done <= 1'b0;
      if (state == st_idle)
      begin
        if (start && cmd.op == flash_pkg::op_program)
          state <= st_prog_set;
        else if (start && cmd.op == flash_pkg::op_read)
          state <= st_read_word;
      end
      else if (rsp.done)
      begin
        req.valid <= 1'b0;
        case (state)
          st_prog_set:  state <= st_prog_data;
          st_prog_data: state <= st_poll;
          st_poll:
          begin
            if (word.status.ready)
            begin
              stat_q <= word.raw[7:0];  // Keeps prog_err and lock_err
              state  <= st_read_array;
            end
          end
          default:
          begin
            if (state == st_read_word)
              stat_q <= flash_pkg::status_ready;
            res_done <= 1'b1;
            state    <= st_idle;
          end
        endcase
      end
      else if (!req.valid)
        req <= '{valid: 1'b1, write: !is_read, addr: addr_q, data: wr_word};
    end
  end

endmodule

// ==== design/flash_bus_ctrl.sv ====
module flash_bus_ctrl (
  input  logic                                clk,
  input  logic                                rst_n,
  input  flash_pkg::flash_req_t               erase_req,
  input  flash_pkg::flash_req_t               word_req,
  output flash_pkg::flash_rsp_t               erase_rsp,
  output flash_pkg::flash_rsp_t               word_rsp,
  output logic                                ce_n,
  output logic                                we_n,
  output logic                                oe_n,
  output logic [flash_pkg::flash_addr_w-1:0]  fl_addr,
  output logic [flash_pkg::flash_data_w-1:0]  dq_out,
  output logic                                dq_oe,
  input  logic [flash_pkg::flash_data_w-1:0]  dq_in
);

  flash_pkg::flash_req_t               sel;
  flash_pkg::flash_req_t               cur;
  logic                                owner_erase;
  logic [2:0]                          cnt;
  logic                                last;
  logic [flash_pkg::flash_data_w-1:0]  rdata_q;

  assign sel  = erase_req.valid ? erase_req : word_req;  // Erase wins a tie
  assign last = cur.valid && cnt == (cur.write ? flash_pkg::we_pulse_cycles + 3'd1
                                               : flash_pkg::rd_latency_cycles);

  // Setup at count 0, pulse for we_pulse_cycles, hold on the last count
  assign ce_n    = !cur.valid;
  assign we_n    = !(cur.valid && cur.write && cnt != 3'd0 &&
                     cnt <= flash_pkg::we_pulse_cycles);
  assign oe_n    = !(cur.valid && !cur.write);
  assign dq_oe   = cur.valid && cur.write;
  assign fl_addr = cur.addr;
  assign dq_out  = cur.data;

  assign erase_rsp = '{done: last && owner_erase, rdata: rdata_q};
  assign word_rsp  = '{done: last && !owner_erase, rdata: rdata_q};

  always_ff @(posedge clk)
  begin
    if (cur.valid && !cur.write && cnt == flash_pkg::rd_latency_cycles - 3'd1)
      rdata_q <= dq_in;  // Sampled after the full output-enable window
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      cur         <= '0;
      cnt         <= 3'd0;
      owner_erase <= 1'b0;
    end
    else if (!cur.valid)
    begin
      if (sel.valid)
      begin
        cur         <= sel;
        cnt         <= 3'd0;
        owner_erase <= erase_req.valid;
      end
    end
    else if (last)
      cur.valid <= 1'b0;
    else
      cnt <= cnt + 3'd1;
  end

endmodule

// ==== design/flash_ctrl_top.sv ====
module flash_ctrl_top (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic [7:0]                          s_awaddr,
  input  logic                                s_awvalid,
  output logic                                s_awready,
  input  logic [31:0]                         s_wdata,
  input  logic [3:0]                          s_wstrb,
  input  logic                                s_wvalid,
  output logic                                s_wready,
  output logic [1:0]                          s_bresp,
  output logic                                s_bvalid,
  input  logic                                s_bready,
  input  logic [7:0]                          s_araddr,
  input  logic                                s_arvalid,
  output logic                                s_arready,
  output logic [31:0]                         s_rdata,
  output logic [1:0]                          s_rresp,
  output logic                                s_rvalid,
  input  logic                                s_rready,
  output logic                                ce_n,
  output logic                                we_n,
  output logic                                oe_n,
  output logic [flash_pkg::flash_addr_w-1:0]  fl_addr,
  output logic [flash_pkg::flash_data_w-1:0]  dq_out,
  output logic                                dq_oe,
  input  logic [flash_pkg::flash_data_w-1:0]  dq_in
);

  flash_pkg::flash_cmd_t    cmd;
  logic                     start;
  flash_pkg::flash_req_t    erase_req;
  flash_pkg::flash_req_t    word_req;
  flash_pkg::flash_rsp_t    erase_rsp;
  flash_pkg::flash_rsp_t    word_rsp;
  flash_pkg::flash_result_t erase_res;
  flash_pkg::flash_result_t word_res;

  flash_axil_regs i_regs (
    .clk       (clk),
    .rst_n     (rst_n),
    .s_awaddr  (s_awaddr),
    .s_awvalid (s_awvalid),
    .s_awready (s_awready),
    .s_wdata   (s_wdata),
    .s_wstrb   (s_wstrb),
    .s_wvalid  (s_wvalid),
    .s_wready  (s_wready),
    .s_bresp   (s_bresp),
    .s_bvalid  (s_bvalid),
    .s_bready  (s_bready),
    .s_araddr  (s_araddr),
    .s_arvalid (s_arvalid),
    .s_arready (s_arready),
    .s_rdata   (s_rdata),
    .s_rresp   (s_rresp),
    .s_rvalid  (s_rvalid),
    .s_rready  (s_rready),
    .cmd       (cmd),
    .start     (start),
    .erase_res (erase_res),
    .word_res  (word_res)
  );

  flash_erase_seq i_erase_seq (
    .clk   (clk),
    .rst_n (rst_n),
    .cmd   (cmd),
    .start (start),
    .req   (erase_req),
    .rsp   (erase_rsp),
    .res   (erase_res)
  );

  flash_word_seq i_word_seq (
    .clk   (clk),
    .rst_n (rst_n),
    .cmd   (cmd),
    .start (start),
    .req   (word_req),
    .rsp   (word_rsp),
    .res   (word_res)
  );

  flash_bus_ctrl i_bus_ctrl (
    .clk       (clk),
    .rst_n     (rst_n),
    .erase_req (erase_req),
    .word_req  (word_req),
    .erase_rsp (erase_rsp),
    .word_rsp  (word_rsp),
    .ce_n      (ce_n),
    .we_n      (we_n),
    .oe_n      (oe_n),
    .fl_addr   (fl_addr),
    .dq_out    (dq_out),
    .dq_oe     (dq_oe),
    .dq_in     (dq_in)
  );

endmodule

// ==== verif/flash_model.sv ====
module flash_model (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                ce_n,
  input  logic                                we_n,
  input  logic                                oe_n,
  input  logic [flash_pkg::flash_addr_w-1:0]  addr,
  input  logic [flash_pkg::flash_data_w-1:0]  dq_out,
  input  logic                                dq_oe,
  output logic [flash_pkg::flash_data_w-1:0]  dq_in
);
  timeunit 1ns;
  timeprecision 100ps;

  typedef enum logic [1:0] {pend_none, pend_unlock, pend_erase, pend_program} pend_e;

  localparam logic [4:0] busy_cycles = 5'd30;

  logic [15:0] mem [256];
  logic        locked [16];
  pend_e       pend;
  logic        show_status;  // Reads return the status register instead of the array
  logic [4:0]  busy_cnt;
  logic [6:0]  err;          // Status bits 6 down to 0
  logic        we_q;
  logic        wr_edge;
  logic [7:0]  word;
  logic [3:0]  blk;

  assign word    = addr[7:0];
  assign blk     = addr[7:4];
  assign wr_edge = !ce_n && dq_oe && we_n && !we_q;  // Bus is latched as we_n rises
  assign dq_in   = (ce_n || oe_n) ? 16'h0000 :
                   show_status ? {8'h00, busy_cnt == 5'd0, err} : mem[word];

  always @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < 256; i++)
        mem[i] <= 16'h1234;
      for (int b = 0; b < 16; b++)
        locked[b] <= 1'b1;
      pend        <= pend_none;
      show_status <= 1'b0;
      busy_cnt    <= 5'd0;
      err         <= 7'd0;
      we_q        <= 1'b1;
    end
    else
    begin
      we_q <= we_n;
      if (busy_cnt != 5'd0)
        busy_cnt <= busy_cnt - 5'd1;
      if (wr_edge)
      begin
        pend <= pend_none;
        case (pend)
          pend_unlock:
          begin
            if (dq_out == flash_pkg::cmd_confirm)
            begin
              locked[blk] <= 1'b0;
              busy_cnt    <= busy_cycles;
            end
          end
          pend_erase:
          begin
            if (dq_out == flash_pkg::cmd_confirm)
            begin
              busy_cnt    <= busy_cycles;
              show_status <= 1'b1;
              if (locked[blk])
                err <= 7'b010_0010;  // erase_err with lock_err
              else
                for (int j = 0; j < 16; j++)
                  mem[{blk, 4'(j)}] <= 16'hffff;
            end
          end
          pend_program:
          begin
            busy_cnt    <= busy_cycles;
            show_status <= 1'b1;
            if (locked[blk])
              err <= 7'b001_0010;  // prog_err with lock_err
            else
              mem[word] <= mem[word] & dq_out;  // Programming only clears bits
          end
          default:
          begin
            case (dq_out)
              flash_pkg::cmd_unlock_set: pend <= pend_unlock;
              flash_pkg::cmd_erase_set:
              begin
                pend <= pend_erase;
                err  <= 7'd0;
              end
              flash_pkg::cmd_program:
              begin
                pend <= pend_program;
                err  <= 7'd0;
              end
              flash_pkg::cmd_read_array: show_status <= 1'b0;
              default: ;
            endcase
          end
        endcase
      end
    end
  end

endmodule

// ==== verif/tb_flash_ctrl.sv ====
module tb_flash_ctrl;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int clk_period_ns    = 8;
  localparam int flash_ops        = 40;   // Erases, programs and reads of all tests, rounded up
  localparam int op_budget_cycles = 625;  // Generous bound for one op including STATUS polling
  localparam int watchdog_ns      = flash_ops * op_budget_cycles * clk_period_ns;

  localparam logic [1:0] resp_okay   = 2'b00;
  localparam logic [1:0] resp_slverr = 2'b10;

  logic                               clk;
  logic                               rst_n;
  logic [7:0]                         s_awaddr;
  logic                               s_awvalid;
  logic                               s_awready;
  logic [31:0]                        s_wdata;
  logic [3:0]                         s_wstrb;
  logic                               s_wvalid;
  logic                               s_wready;
  logic [1:0]                         s_bresp;
  logic                               s_bvalid;
  logic                               s_bready;
  logic [7:0]                         s_araddr;
  logic                               s_arvalid;
  logic                               s_arready;
  logic [31:0]                        s_rdata;
  logic [1:0]                         s_rresp;
  logic                               s_rvalid;
  logic                               s_rready;
  logic                               ce_n;
  logic                               we_n;
  logic                               oe_n;
  logic [flash_pkg::flash_addr_w-1:0] fl_addr;
  logic [flash_pkg::flash_data_w-1:0] dq_out;
  logic                               dq_oe;
  logic [flash_pkg::flash_data_w-1:0] dq_in;
  logic [31:0]                        rng_state;

  flash_ctrl_top i_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .s_awaddr  (s_awaddr),
    .s_awvalid (s_awvalid),
    .s_awready (s_awready),
    .s_wdata   (s_wdata),
    .s_wstrb   (s_wstrb),
    .s_wvalid  (s_wvalid),
    .s_wready  (s_wready),
    .s_bresp   (s_bresp),
    .s_bvalid  (s_bvalid),
    .s_bready  (s_bready),
    .s_araddr  (s_araddr),
    .s_arvalid (s_arvalid),
    .s_arready (s_arready),
    .s_rdata   (s_rdata),
    .s_rresp   (s_rresp),
    .s_rvalid  (s_rvalid),
    .s_rready  (s_rready),
    .ce_n      (ce_n),
    .we_n      (we_n),
    .oe_n      (oe_n),
    .fl_addr   (fl_addr),
    .dq_out    (dq_out),
    .dq_oe     (dq_oe),
    .dq_in     (dq_in)
  );

  flash_model i_flash (
    .clk    (clk),
    .rst_n  (rst_n),
    .ce_n   (ce_n),
    .we_n   (we_n),
    .oe_n   (oe_n),
    .addr   (fl_addr),
    .dq_out (dq_out),
    .dq_oe  (dq_oe),
    .dq_in  (dq_in)
  );

  always #(clk_period_ns / 2) clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("Finished with errors");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
    if (got !== exp)
      stop_with_failure($sformatf("** Error at %0t ns: %s is %h, expected %h",
                                  $time, name, got, exp));
  endtask

  task automatic check_word(input string name, input logic [flash_pkg::flash_data_w-1:0] got,
                            input logic [flash_pkg::flash_data_w-1:0] exp);
    if (got !== exp)
      stop_with_failure($sformatf("** Error at %0t ns: %s is %h, expected %h",
                                  $time, name, got, exp));
  endtask

  task automatic check_status(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp)
      stop_with_failure($sformatf("** Error at %0t ns: %s is %h, expected %h",
                                  $time, name, got, exp));
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
      stop_with_failure($sformatf("** Error at %0t ns: %s is %b, expected %b",
                                  $time, name, got, exp));
  endtask

  task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
                           output logic [1:0] resp);
    logic aw_taken;
    logic w_taken;
    aw_taken = 1'b0;
    w_taken  = 1'b0;
    @(posedge clk);
    s_awaddr  <= addr;
    s_awvalid <= 1'b1;
    s_wdata   <= data;
    s_wstrb   <= 4'hf;
    s_wvalid  <= 1'b1;
    s_bready  <= 1'b1;
    while (!(aw_taken && w_taken))
    begin
      @(posedge clk);
      if (s_awvalid && s_awready)
      begin
        aw_taken = 1'b1;
        s_awvalid <= 1'b0;
      end
      if (s_wvalid && s_wready)
      begin
        w_taken = 1'b1;
        s_wvalid <= 1'b0;
      end
    end
    @(posedge clk);
    while (!s_bvalid)
      @(posedge clk);
    resp = s_bresp;
    s_bready <= 1'b0;
  endtask

  task automatic axi_read(input logic [7:0] addr, output logic [31:0] data,
                          output logic [1:0] resp);
    @(posedge clk);
    s_araddr  <= addr;
    s_arvalid <= 1'b1;
    s_rready  <= 1'b1;
    @(posedge clk);
    while (!s_arready)
      @(posedge clk);
    s_arvalid <= 1'b0;
    @(posedge clk);
    while (!s_rvalid)
      @(posedge clk);
    data = s_rdata;
    resp = s_rresp;
    s_rready <= 1'b0;
  endtask

  task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
    logic [1:0] resp;
    axi_write(addr, data, resp);
    check_resp($sformatf("write response at offset %h", addr), resp, resp_okay);
  endtask

  // STATUS bit 1 is done and bit 0 is busy
  task automatic poll_done(output logic [7:0] stat);
    logic [31:0] data;
    logic [1:0]  resp;
    data = 32'd0;
    while (!data[1])
    begin
      axi_read(flash_pkg::reg_status, data, resp);
      check_resp("STATUS read response", resp, resp_okay);
    end
    check_flag("STATUS busy with done set", data[0], 1'b0);
    stat = data[15:8];
  endtask

  task automatic erase_block(input logic [flash_pkg::flash_addr_w-1:0] addr,
                             output logic [7:0] stat);
    write_reg(flash_pkg::reg_addr, 32'(addr));
    write_reg(flash_pkg::reg_cmd, 32'h1);
    poll_done(stat);
  endtask

  task automatic program_word(input logic [flash_pkg::flash_addr_w-1:0] addr,
                              input logic [flash_pkg::flash_data_w-1:0] value,
                              output logic [7:0] stat);
    write_reg(flash_pkg::reg_addr, 32'(addr));
    write_reg(flash_pkg::reg_wdata, 32'(value));
    write_reg(flash_pkg::reg_cmd, 32'h2);
    poll_done(stat);
  endtask

  task automatic read_word(input logic [flash_pkg::flash_addr_w-1:0] addr,
                           output logic [flash_pkg::flash_data_w-1:0] value);
    logic [7:0]  stat;
    logic [31:0] data;
    logic [1:0]  resp;
    write_reg(flash_pkg::reg_addr, 32'(addr));
    write_reg(flash_pkg::reg_cmd, 32'h4);
    poll_done(stat);
    check_status("word read status", stat, 8'h80);
    axi_read(flash_pkg::reg_rdata, data, resp);
    check_resp("RDATA read response", resp, resp_okay);
    value = data[15:0];
  endtask

  task automatic reset_state();
    logic [31:0] data;
    logic [1:0]  resp;
    check_flag("ce_n after reset", ce_n, 1'b1);
    check_flag("we_n after reset", we_n, 1'b1);
    check_flag("oe_n after reset", oe_n, 1'b1);
    check_flag("dq_oe after reset", dq_oe, 1'b0);
    axi_read(flash_pkg::reg_status, data, resp);
    check_resp("STATUS read response", resp, resp_okay);
    check_status("STATUS byte after reset", data[15:8], 8'h00);
    check_flag("STATUS busy after reset", data[0], 1'b0);
    check_flag("STATUS done after reset", data[1], 1'b0);
    axi_read(8'h14, data, resp);
    check_resp("unmapped offset read response", resp, resp_slverr);
  endtask

  task automatic erase_block_two();
    logic [7:0]  stat;
    logic [15:0] value;
    erase_block(25'h020, stat);
    check_status("erase status of block 2", stat, 8'h80);
    for (int i = 0; i < 16; i++)
    begin
      read_word(25'h020 + 25'(i), value);
      check_word($sformatf("word %0d of block 2", i), value, 16'hffff);
    end
    read_word(25'h035, value);
    check_word("word 5 of block 3", value, 16'h1234);
  endtask

  task automatic program_random_words();
    logic [7:0]  stat;
    logic [15:0] wr_value;
    logic [15:0] rd_value;
    for (int i = 0; i < 6; i++)
    begin
      rng_state = xorshift32(rng_state);
      wr_value  = rng_state[15:0];
      program_word(25'h020 + 25'(i), wr_value, stat);
      check_status("program status in block 2", stat, 8'h80);
      read_word(25'h020 + 25'(i), rd_value);
      check_word($sformatf("programmed word %0d of block 2", i), rd_value,
                 wr_value & 16'hffff);
    end
  endtask

  task automatic program_locked_block();
    logic [7:0]  stat;
    logic [15:0] value;
    program_word(25'h053, 16'h0f0f, stat);
    check_status("program status in locked block 5", stat, 8'h92);
    read_word(25'h053, value);
    check_word("word 3 of locked block 5", value, 16'h1234);
  endtask

  task automatic command_while_busy();
    logic [1:0]  resp;
    logic [7:0]  stat;
    logic [15:0] value;
    write_reg(flash_pkg::reg_addr, 32'h70);
    write_reg(flash_pkg::reg_wdata, 32'h0);
    write_reg(flash_pkg::reg_cmd, 32'h1);
    axi_write(flash_pkg::reg_cmd, 32'h2, resp);  // Program of 0x0000 while the erase runs
    check_resp("CMD write while busy", resp, resp_slverr);
    poll_done(stat);
    check_status("erase status of block 7", stat, 8'h80);
    read_word(25'h070, value);
    check_word("word 0 of block 7", value, 16'hffff);
  endtask

  task automatic invalid_command();
    logic [31:0] data;
    logic [1:0]  resp;
    axi_write(flash_pkg::reg_cmd, 32'h3, resp);
    check_resp("CMD write with two op bits", resp, resp_slverr);
    axi_read(flash_pkg::reg_status, data, resp);
    check_resp("STATUS read response", resp, resp_okay);
    check_flag("STATUS busy after invalid CMD", data[0], 1'b0);
  endtask

  initial
  begin
    #(watchdog_ns);
    stop_with_failure("Watchdog timeout, the tests did not complete in time");
  end

  initial
  begin
    clk       = 1'b0;
    rst_n     = 1'b0;
    s_awaddr  = 8'd0;
    s_awvalid = 1'b0;
    s_wdata   = 32'd0;
    s_wstrb   = 4'd0;
    s_wvalid  = 1'b0;
    s_bready  = 1'b0;
    s_araddr  = 8'd0;
    s_arvalid = 1'b0;
    s_rready  = 1'b0;
    rng_state = 32'h00f13a40;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    reset_state();
    erase_block_two();
    program_random_words();
    program_locked_block();
    command_while_busy();
    invalid_command();
    $display("Finished with no errors");
    $finish;
  end

endmodule

// ==== filelist.f ====
design/flash_pkg.sv
design/flash_axil_regs.sv
design/flash_erase_seq.sv
design/flash_word_seq.sv
design/flash_bus_ctrl.sv
design/flash_ctrl_top.sv
verif/flash_model.sv
verif/tb_flash_ctrl.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps \
  -f filelist.f --top-module tb_flash_ctrl \
  --Mdir obj_dir -o sim_flash_ctrl

./obj_dir/sim_flash_ctrl > sim.log 2>&1 || true
cat sim.log

if grep -q "Finished with errors" sim.log; then
  echo "Simulation failed, see sim.log"
  exit 1
fi

if ! grep -q "Finished with no errors" sim.log; then
  echo "Simulation ended without a result, see sim.log"
  exit 1
fi

echo "Simulation passed"
